/* Makefile */
TOP := fixed_linear_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* design/accumulator.sv */
`timescale 1ns/100ps
`default_nettype none

`include "linear_config.svh"

module accumulator import fixed_types_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     acc_add,
  input  logic     acc_clear,
  input  dp_vec_t  dp_sum,
  output acc_vec_t partial
);

  for (genvar i = 0; i < `PARALLELISM; i++) begin : g_lane
    acc_t dp_ext;

    assign dp_ext = acc_t'($signed(dp_sum[i]));

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        partial[i] <= '0;
      end else if (acc_add && acc_clear) begin
        // first beat of a vector starts the sum afresh
        partial[i] <= dp_ext;
      end else if (acc_add) begin
        partial[i] <= partial[i] + dp_ext;
      end else if (acc_clear) begin
        // the output stage takes the final sum, so the lane goes back to zero
        partial[i] <= '0;
      end
    end
  end

endmodule

`default_nettype wire

/* design/bias_output_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "linear_config.svh"

module bias_output_stage import fixed_types_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      out_load,
  input  acc_vec_t  partial,
  input  dp_vec_t   dp_sum,
  input  bias_vec_t bias,
  output out_vec_t  data_out
);

  // bias has fewer fraction bits than the product, so it moves left
  localparam int BIAS_SHIFT = `OUT_FRAC_WIDTH - `BIAS_FRAC_WIDTH;

  out_vec_t sum;

  for (genvar i = 0; i < `PARALLELISM; i++) begin : g_lane
    out_t bias_aligned;
    out_t partial_ext;
    out_t dp_ext;

    assign bias_aligned = out_t'($signed(bias[i])) <<< BIAS_SHIFT;
    assign partial_ext  = out_t'($signed(partial[i]));
    assign dp_ext       = out_t'($signed(dp_sum[i]));

    // the last dot product has not reached the accumulator yet,
    // so it is folded in here together with the bias
    assign sum[i] = partial_ext + dp_ext + bias_aligned;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      data_out <= '0;
    end else if (out_load) begin
      data_out <= sum;
    end
  end

endmodule

`default_nettype wire

/* design/dot_product.sv */
`timescale 1ns/100ps
`default_nettype none

`include "linear_config.svh"

module dot_product import fixed_types_pkg::*; (
  input  logic        clk,
  input  logic        dp_load,
  input  in_vec_t     data_in,
  input  weight_vec_t weight,
  output dp_vec_t     dp_sum
);

  localparam int NODES = 2 * `IN_SIZE - 1;

  for (genvar i = 0; i < `PARALLELISM; i++) begin : g_neuron
    // heap-ordered tree, leaves sit at the top IN_SIZE nodes and node 0 is the root
    dp_t node [NODES];

    always_comb begin
      prod_t prod;
      for (int j = 0; j < `IN_SIZE; j++) begin
        prod = prod_t'($signed(data_in[j]) * $signed(weight[i*`IN_SIZE + j]));
        node[`IN_SIZE - 1 + j] = dp_t'(prod);
      end
      for (int k = `IN_SIZE - 2; k >= 0; k--) begin
        node[k] = node[2*k + 1] + node[2*k + 2];
      end
    end

    // result lands one cycle after the beat is taken
    always_ff @(posedge clk) begin
      if (dp_load) begin
        dp_sum[i] <= node[0];
      end
    end
  end

endmodule

`default_nettype wire

/* design/fixed_linear.sv */
`timescale 1ns/100ps
`default_nettype none

`include "linear_config.svh"

module fixed_linear import fixed_types_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  input  in_vec_t     data_in,
  input  logic        data_in_valid,
  output logic        data_in_ready,

  input  weight_vec_t weight,
  input  logic        weight_valid,
  output logic        weight_ready,

  input  bias_vec_t   bias,
  input  logic        bias_valid,
  output logic        bias_ready,

  output out_vec_t    data_out,
  output logic        data_out_valid,
  input  logic        data_out_ready
);

  logic     dp_load;
  logic     acc_add;
  logic     acc_clear;
  logic     out_load;
  dp_vec_t  dp_sum;
  acc_vec_t partial;

  linear_ctrl u_linear_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_in_valid  (data_in_valid),
    .weight_valid   (weight_valid),
    .bias_valid     (bias_valid),
    .data_out_ready (data_out_ready),
    .data_in_ready  (data_in_ready),
    .weight_ready   (weight_ready),
    .bias_ready     (bias_ready),
    .data_out_valid (data_out_valid),
    .dp_load        (dp_load),
    .acc_add        (acc_add),
    .acc_clear      (acc_clear),
    .out_load       (out_load)
  );

  dot_product u_dot_product (
    .clk     (clk),
    .dp_load (dp_load),
    .data_in (data_in),
    .weight  (weight),
    .dp_sum  (dp_sum)
  );

  accumulator u_accumulator (
    .clk       (clk),
    .rst_n     (rst_n),
    .acc_add   (acc_add),
    .acc_clear (acc_clear),
    .dp_sum    (dp_sum),
    .partial   (partial)
  );

  bias_output_stage u_bias_output_stage (
    .clk      (clk),
    .rst_n    (rst_n),
    .out_load (out_load),
    .partial  (partial),
    .dp_sum   (dp_sum),
    .bias     (bias),
    .data_out (data_out)
  );

endmodule

`default_nettype wire

/* design/fixed_types_pkg.sv */
`default_nettype none

package fixed_types_pkg;

  `include "linear_config.svh"

  // scalar words
  typedef logic signed [`IN_WIDTH-1:0]     in_t;
  typedef logic signed [`WEIGHT_WIDTH-1:0] weight_t;
  typedef logic signed [`BIAS_WIDTH-1:0]   bias_t;
  typedef logic signed [`PROD_WIDTH-1:0]   prod_t;
  typedef logic signed [`DP_WIDTH-1:0]     dp_t;
  typedef logic signed [`ACC_WIDTH-1:0]    acc_t;
  typedef logic signed [`OUT_WIDTH-1:0]    out_t;

  // lane arrays, neuron i owns weights i*IN_SIZE up to i*IN_SIZE+IN_SIZE-1
  typedef in_t     [`IN_SIZE-1:0]                in_vec_t;
  typedef weight_t [`PARALLELISM*`IN_SIZE-1:0]   weight_vec_t;
  typedef bias_t   [`PARALLELISM-1:0]            bias_vec_t;
  typedef dp_t     [`PARALLELISM-1:0]            dp_vec_t;
  typedef acc_t    [`PARALLELISM-1:0]            acc_vec_t;
  typedef out_t    [`PARALLELISM-1:0]            out_vec_t;

endpackage

`default_nettype wire

/* design/linear_config.svh */
`ifndef LINEAR_CONFIG_SVH
`define LINEAR_CONFIG_SVH

// element formats, all signed two's complement
`define IN_WIDTH 8
`define IN_FRAC_WIDTH 2
`define WEIGHT_WIDTH 8
`define WEIGHT_FRAC_WIDTH 2
`define BIAS_WIDTH 12
`define BIAS_FRAC_WIDTH 1

// layer geometry
`define IN_SIZE 4
`define IN_DEPTH 3
`define PARALLELISM 2

// widths grow along the datapath so no stage can overflow
`define PROD_WIDTH (`IN_WIDTH + `WEIGHT_WIDTH)
`define DP_WIDTH (`PROD_WIDTH + $clog2(`IN_SIZE))
`define ACC_WIDTH (`DP_WIDTH + $clog2(`IN_DEPTH))
`define OUT_WIDTH (`ACC_WIDTH + 1)
`define OUT_FRAC_WIDTH (`IN_FRAC_WIDTH + `WEIGHT_FRAC_WIDTH)
`define BEAT_WIDTH $clog2(`IN_DEPTH)

`endif

/* design/linear_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "linear_config.svh"

module linear_ctrl import linear_ctrl_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic data_in_valid,
  input  logic weight_valid,
  input  logic bias_valid,
  input  logic data_out_ready,
  output logic data_in_ready,
  output logic weight_ready,
  output logic bias_ready,
  output logic data_out_valid,
  output logic dp_load,
  output logic acc_add,
  output logic acc_clear,
  output logic out_load
);

  logic  dp_valid;
  beat_t take_beat;
  beat_t held_beat;
  logic  held_first;
  logic  held_last;
  logic  out_free;
  logic  advance;
  logic  slice_take;
  logic  beat_take;

  assign held_first = held_beat == '0;
  assign held_last  = held_beat == LAST_BEAT;

  // output register can load when empty or being drained this cycle
  assign out_free = !data_out_valid || data_out_ready;

  // a last beat needs the bias and room at the output, other beats just go
  assign advance = dp_valid && (!held_last || (bias_valid && out_free));

  assign slice_take = !dp_valid || advance;
  assign beat_take  = data_in_valid && weight_valid && slice_take;

  assign data_in_ready = weight_valid && slice_take;
  assign weight_ready  = data_in_valid && slice_take;
  assign bias_ready    = dp_valid && held_last && out_free && bias_valid;

  assign dp_load   = beat_take;
  assign acc_add   = advance && !held_last;
  assign acc_clear = advance && (held_first || held_last);
  assign out_load  = advance && held_last;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dp_valid       <= 1'b0;
      take_beat      <= '0;
      held_beat      <= '0;
      data_out_valid <= 1'b0;
    end else begin
      if (beat_take) begin
        dp_valid  <= 1'b1;
        held_beat <= take_beat;
        take_beat <= (take_beat == LAST_BEAT) ? '0 : take_beat + 1'b1;
      end else if (advance) begin
        dp_valid <= 1'b0;
      end

      if (out_load) begin
        data_out_valid <= 1'b1;
      end else if (data_out_ready) begin
        data_out_valid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* design/linear_ctrl_pkg.sv */
`default_nettype none

package linear_ctrl_pkg;

  `include "linear_config.svh"

  typedef logic [`BEAT_WIDTH-1:0] beat_t;

  // index of the final slice in a vector
  localparam beat_t LAST_BEAT = beat_t'(`IN_DEPTH - 1);

endpackage

`default_nettype wire

/* project.f */
+incdir+design
design/fixed_types_pkg.sv
design/linear_ctrl_pkg.sv
design/dot_product.sv
design/accumulator.sv
design/bias_output_stage.sv
design/linear_ctrl.sv
design/fixed_linear.sv
verification/fixed_linear_props.sv
verification/fixed_linear_tb.sv

/* verification/fixed_linear_props.sv */
`timescale 1ns/100ps
`default_nettype none

`include "linear_config.svh"

module fixed_linear_props import fixed_types_pkg::*; (
  input logic     clk,
  input logic     rst_n,
  input in_vec_t  data_in,
  input logic     data_in_valid,
  input logic     data_in_ready,
  input logic     weight_valid,
  input logic     weight_ready,
  input logic     bias_valid,
  input logic     bias_ready,
  input out_vec_t data_out,
  input logic     data_out_valid,
  input logic     data_out_ready
);

  // beats taken since the last bias transfer, one full vector allows a bias
  int beats_open;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beats_open <= 0;
    end else begin
      beats_open <= beats_open + ((weight_valid && weight_ready) ? 1 : 0)
                    - ((bias_valid && bias_ready) ? `IN_DEPTH : 0);
    end
  end

  a_out_held: assert property (@(posedge clk) disable iff (!rst_n)
    data_out_valid && !data_out_ready |=> data_out_valid && $stable(data_out))
    else $error("data_out dropped or changed before its transfer");

  a_in_held: assert property (@(posedge clk) disable iff (!rst_n)
    data_in_valid && !data_in_ready |=> data_in_valid && $stable(data_in))
    else $error("data_in dropped or changed before its transfer");

  a_reset_quiet: assert property (@(posedge clk) !rst_n |=> !data_out_valid)
    else $error("data_out_valid high after a reset cycle");

  a_bias_after_last: assert property (@(posedge clk) disable iff (!rst_n)
    bias_ready |-> beats_open == `IN_DEPTH)
    else $error("bias_ready high before the last beat of the vector was taken");

endmodule

bind fixed_linear fixed_linear_props u_fixed_linear_props (
  .clk            (clk),
  .rst_n          (rst_n),
  .data_in        (data_in),
  .data_in_valid  (data_in_valid),
  .data_in_ready  (data_in_ready),
  .weight_valid   (weight_valid),
  .weight_ready   (weight_ready),
  .bias_valid     (bias_valid),
  .bias_ready     (bias_ready),
  .data_out       (data_out),
  .data_out_valid (data_out_valid),
  .data_out_ready (data_out_ready)
);

`default_nettype wire

/* verification/fixed_linear_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "linear_config.svh"

module fixed_linear_tb import fixed_types_pkg::*; ();

  localparam int CYCLE_LIMIT = 4000;

  logic        clk;
  logic        rst_n;
  in_vec_t     data_in;
  logic        data_in_valid;
  logic        data_in_ready;
  weight_vec_t weight;
  logic        weight_valid;
  logic        weight_ready;
  bias_vec_t   bias;
  logic        bias_valid;
  logic        bias_ready;
  out_vec_t    data_out;
  logic        data_out_valid;
  logic        data_out_ready;

  // slices, biases and expected words wait here until the drivers take them
  in_vec_t     slice_in_q[$];
  weight_vec_t slice_w_q[$];
  bias_vec_t   bias_q[$];
  longint      expect_q[$];
  out_vec_t    got_q[$];

  in_vec_t     cur_in[`IN_DEPTH];
  weight_vec_t cur_w[`IN_DEPTH];

  int unsigned lcg_state = 22270;
  int          cycle_count;
  int          error_count;
  int          test_count;
  int          failed_tests;
  int          stall_seen;
  int          unstable_seen;
  logic        out_held;
  out_vec_t    out_last;

  fixed_linear u_fixed_linear (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_in        (data_in),
    .data_in_valid  (data_in_valid),
    .data_in_ready  (data_in_ready),
    .weight         (weight),
    .weight_valid   (weight_valid),
    .weight_ready   (weight_ready),
    .bias           (bias),
    .bias_valid     (bias_valid),
    .bias_ready     (bias_ready),
    .data_out       (data_out),
    .data_out_valid (data_out_valid),
    .data_out_ready (data_out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // inputs change only on the falling edge, so 1 ns later everything has settled
  // and a valid/ready pair seen here transfers on the next rising edge
  always begin
    @(negedge clk);
    #1;
    if (out_held && data_out !== out_last) begin
      unstable_seen++;
    end
    out_held = data_out_valid && !data_out_ready;
    out_last = data_out;
    if (data_out_valid && data_out_ready) begin
      got_q.push_back(data_out);
    end
    if (data_in_valid && weight_valid && !data_in_ready) begin
      stall_seen++;
    end
  end

  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];
  endfunction

  // layer output of one neuron in plain integers with the bias moved from 1 to 4 fraction bits
  function automatic longint neuron_expect(input int n, input bias_vec_t b);
    longint sum;
    sum = 0;
    for (int d = 0; d < `IN_DEPTH; d++) begin
      for (int j = 0; j < `IN_SIZE; j++) begin
        sum += longint'($signed(cur_in[d][j])) * longint'($signed(cur_w[d][n*`IN_SIZE + j]));
      end
    end
    return sum + (longint'($signed(b[n])) <<< 3);
  endfunction

  task automatic queue_vector(input bias_vec_t b);
    for (int d = 0; d < `IN_DEPTH; d++) begin
      slice_in_q.push_back(cur_in[d]);
      slice_w_q.push_back(cur_w[d]);
    end
    bias_q.push_back(b);
    for (int n = 0; n < `PARALLELISM; n++) begin
      expect_q.push_back(neuron_expect(n, b));
    end
  endtask

  task automatic queue_random_vector();
    bias_vec_t b;
    for (int d = 0; d < `IN_DEPTH; d++) begin
      for (int j = 0; j < `IN_SIZE; j++) begin
        cur_in[d][j] = in_t'(lcg_next());
      end
      for (int k = 0; k < `PARALLELISM*`IN_SIZE; k++) begin
        cur_w[d][k] = weight_t'(lcg_next());
      end
    end
    for (int n = 0; n < `PARALLELISM; n++) begin
      b[n] = bias_t'(lcg_next());
    end
    queue_vector(b);
  endtask

  task automatic drive_slices();
    while (slice_in_q.size() > 0) begin
      @(negedge clk);
      data_in = slice_in_q.pop_front();
      weight = slice_w_q.pop_front();
      data_in_valid = 1'b1;
      weight_valid = 1'b1;
      #1;
      while (!(data_in_ready && weight_ready)) begin
        @(negedge clk);
        #1;
      end
    end
    @(negedge clk);
    data_in_valid = 1'b0;
    weight_valid = 1'b0;
  endtask

  task automatic drive_bias(input int delay);
    while (bias_q.size() > 0) begin
      repeat (delay) @(negedge clk);
      @(negedge clk);
      bias = bias_q.pop_front();
      bias_valid = 1'b1;
      #1;
      while (!bias_ready) begin
        @(negedge clk);
        #1;
      end
      @(negedge clk);
      bias_valid = 1'b0;
    end
  endtask

  task automatic drive_out_ready(input int stall);
    if (stall > 0) begin
      @(negedge clk);
      data_out_ready = 1'b0;
      repeat (stall) @(negedge clk);
      data_out_ready = 1'b1;
    end
  endtask

  task automatic run_vectors(input string name, input int delay, input int stall,
                             output int errs);
    int       n_exp;
    longint   exp_val;
    longint   act_val;
    out_vec_t got;
    errs = 0;
    n_exp = expect_q.size();
    got_q.delete();
    fork
      drive_slices();
      drive_bias(delay);
      drive_out_ready(stall);
    join
    while (got_q.size() * `PARALLELISM < n_exp) begin
      @(negedge clk);
    end
    for (int v = 0; v < n_exp / `PARALLELISM; v++) begin
      got = got_q.pop_front();
      for (int n = 0; n < `PARALLELISM; n++) begin
        exp_val = expect_q.pop_front();
        act_val = longint'($signed(got[n]));
        if (act_val != exp_val) begin
          $display("mismatch %s: vector %0d neuron %0d expected %0d actual %0d",
                   name, v, n, exp_val, act_val);
          errs++;
        end
      end
    end
    repeat (4) @(negedge clk);
    if (got_q.size() != 0) begin
      $display("%s: %0d outputs appeared with no vector behind them", name, got_q.size());
      errs++;
    end
  endtask

  task automatic finish_test(input string name, input int errs);
    test_count++;
    error_count += errs;
    if (errs == 0) begin
      $display("%s: ok", name);
    end else begin
      failed_tests++;
      $display("%s: %0d errors", name, errs);
    end
  endtask

  task automatic test_idle_after_reset();
    int errs;
    errs = 0;
    repeat (4) begin
      @(negedge clk);
      #1;
      if (data_out_valid || data_in_ready || weight_ready || bias_ready) begin
        $display("idle_after_reset: a ready or data_out_valid is high with no input");
        errs++;
      end
    end
    finish_test("idle_after_reset", errs);
  endtask

  // inputs run from 0.25 up to 3.0 while neuron 0 weighs them by 1.0 and neuron 1 by -0.25 per lane
  task automatic set_hand_operands();
    for (int d = 0; d < `IN_DEPTH; d++) begin
      for (int j = 0; j < `IN_SIZE; j++) begin
        cur_in[d][j] = in_t'(d * `IN_SIZE + j + 1);
        cur_w[d][j] = weight_t'(4);
        cur_w[d][`IN_SIZE + j] = weight_t'(-(j + 1));
      end
    end
  endtask

  task automatic test_hand_vector();
    int errs;
    set_hand_operands();
    queue_vector('0);
    run_vectors("hand_vector", 0, 0, errs);
    finish_test("hand_vector", errs);
  endtask

  task automatic test_negative_bias();
    bias_vec_t b;
    int        errs;
    set_hand_operands();
    b[0] = bias_t'(-5);
    b[1] = bias_t'(-12);
    queue_vector(b);
    run_vectors("negative_bias", 0, 0, errs);
    finish_test("negative_bias", errs);
  endtask

  task automatic test_random_stream();
    int errs;
    repeat (6) queue_random_vector();
    run_vectors("random_stream", 0, 0, errs);
    finish_test("random_stream", errs);
  endtask

  task automatic test_output_stall();
    int errs;
    stall_seen = 0;
    unstable_seen = 0;
    repeat (3) queue_random_vector();
    run_vectors("output_stall", 0, 20, errs);
    if (stall_seen == 0) begin
      $display("output_stall: data_in_ready never dropped while the output was held");
      errs++;
    end
    if (unstable_seen != 0) begin
      $display("output_stall: data_out changed while it waited for data_out_ready");
      errs++;
    end
    finish_test("output_stall", errs);
  endtask

  task automatic test_late_bias();
    int errs;
    repeat (3) queue_random_vector();
    run_vectors("late_bias", 6, 0, errs);
    finish_test("late_bias", errs);
  endtask

  initial begin
    cycle_count = 0;
    error_count = 0;
    test_count = 0;
    failed_tests = 0;
    stall_seen = 0;
    unstable_seen = 0;
    out_held = 1'b0;
    out_last = '0;
    rst_n = 1'b0;
    data_in = '0;
    data_in_valid = 1'b0;
    weight = '0;
    weight_valid = 1'b0;
    bias = '0;
    bias_valid = 1'b0;
    data_out_ready = 1'b1;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    test_idle_after_reset();
    test_hand_vector();
    test_negative_bias();
    test_random_stream();
    test_output_stall();
    test_late_bias();

    $display("tests run %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
